// File: compile.f
+incdir+include
hw/pit_pkg.sv
hw/pit_chan_if.sv
hw/pit_decode.sv
hw/pit_chan_regs.sv
hw/pit_counter.sv
hw/pit_readback.sv
hw/pit_top.sv
test/tb_pit.sv

// File: hw/pit_chan_if.sv
`default_nettype none
`timescale 1ns/10ps

interface pit_chan_if;

  // Bus strobes, one-cycle pulses
  logic        cw_wr;
  logic        cnt_wr;
  logic        latch_cmd;
  logic        rd_sel;
  // Any read on the bus, clears stale read bytes
  logic        rd_any;

  // Channel setup and reload value
  logic [2:0]  mode;
  logic [1:0]  access;
  logic [15:0] reload_val;
  logic        load;

  // Running count
  logic [15:0] count;

  modport decoder  (output cw_wr, cnt_wr, latch_cmd, rd_sel, rd_any);
  modport regs     (input cw_wr, cnt_wr, output mode, access, reload_val, load);
  modport counter  (input cw_wr, mode, reload_val, load, output count);
  modport readback (input cw_wr, latch_cmd, rd_sel, rd_any, access, count);

endinterface

`default_nettype wire

// File: hw/pit_chan_regs.sv
`default_nettype none
`timescale 1ns/10ps

module pit_chan_regs (
  input  wire                       CLK,
  input  wire                       rst,
  input  wire [pit_pkg::BYTE_W-1:0] wdata,
  pit_chan_if.regs                  ch
);

  localparam int CW = pit_pkg::COUNT_W;
  localparam int BW = pit_pkg::BYTE_W;

  pit_pkg::pit_mode_e   mode_q;
  pit_pkg::pit_mode_e   mode_d;
  pit_pkg::pit_access_e access_q;
  logic [CW-1:0]        cnt_q;
  logic                 wr_msb;
  logic                 load_q;

  // M1:M0 picks the mode, M2 only separates the dropped modes
  always_comb begin
    case (wdata[2:1])
      2'b10:   mode_d = pit_pkg::MODE_RATE_GEN;
      2'b11:   mode_d = pit_pkg::MODE_SQUARE;
      default: mode_d = pit_pkg::MODE_TC_INT;
    endcase
  end

  always_ff @(posedge CLK) begin
    if (rst) begin
      mode_q   <= pit_pkg::MODE_TC_INT;
      access_q <= pit_pkg::ACC_LSB;
      wr_msb   <= 1'b0;
      load_q   <= 1'b0;
    end else begin
      load_q <= 1'b0;
      if (ch.cw_wr) begin
        mode_q   <= mode_d;
        access_q <= pit_pkg::pit_access_e'(wdata[5:4]);
        wr_msb   <= 1'b0;
      end else if (ch.cnt_wr) begin
        if (access_q == pit_pkg::ACC_BOTH) begin
          // Load only once the MSB has arrived
          wr_msb <= ~wr_msb;
          load_q <= wr_msb;
        end else begin
          load_q <= 1'b1;
        end
      end
    end
  end

  // Count bytes, single-byte modes zero the other half
  always_ff @(posedge CLK) begin
    if (ch.cnt_wr) begin
      case (access_q)
        pit_pkg::ACC_LSB: cnt_q <= {{BW{1'b0}}, wdata};
        pit_pkg::ACC_MSB: cnt_q <= {wdata, {BW{1'b0}}};
        default: begin
          if (wr_msb) begin
            cnt_q[CW-1:BW] <= wdata;
          end else begin
            cnt_q[BW-1:0] <= wdata;
          end
        end
      endcase
    end
  end

  // Square wave runs on the count rounded down to even
  assign ch.reload_val = (mode_q == pit_pkg::MODE_SQUARE) ? {cnt_q[CW-1:1], 1'b0} : cnt_q;
  assign ch.mode       = mode_q;
  assign ch.access     = access_q;
  assign ch.load       = load_q;

  a_load_pulse: assert property (@(posedge CLK) disable iff (rst) ch.load |=> !ch.load)
    else $error("pit_chan_regs: load held for two cycles");

endmodule

`default_nettype wire

// File: hw/pit_counter.sv
`default_nettype none
`timescale 1ns/10ps

module pit_counter (
  input  wire         CLK,
  input  wire         rst,
  input  wire         gate,
  output logic        out,
  pit_chan_if.counter ch
);

  pit_pkg::pit_mode_e            mode;
  logic [pit_pkg::COUNT_W-1:0]   count_q;
  logic                          armed;
  logic                          out_q;
  logic                          periodic;

  assign mode     = pit_pkg::pit_mode_e'(ch.mode);
  assign periodic = (mode == pit_pkg::MODE_RATE_GEN) || (mode == pit_pkg::MODE_SQUARE);

  always_ff @(posedge CLK) begin
    if (rst) begin
      count_q <= '0;
      armed   <= 1'b0;
      out_q   <= 1'b0;
    end else if (ch.cw_wr) begin
      // New control word stops counting until the next load
      armed <= 1'b0;
    end else if (ch.load) begin
      count_q <= ch.reload_val;
      armed   <= 1'b1;
      out_q   <= periodic;
    end else if (armed && gate) begin
      case (mode)
        pit_pkg::MODE_RATE_GEN: begin
          // One low cycle per period, then reload
          if (count_q == 1) begin
            count_q <= ch.reload_val;
            out_q   <= 1'b0;
          end else begin
            count_q <= count_q - 1;
            out_q   <= 1'b1;
          end
        end
        pit_pkg::MODE_SQUARE: begin
          if (count_q == 2) begin
            count_q <= ch.reload_val;
            out_q   <= ~out_q;
          end else begin
            count_q <= count_q - 2;
          end
        end
        default: begin
          // Terminal count, OUT stays high while the count wraps
          count_q <= count_q - 1;
          if (count_q == 1) begin
            out_q <= 1'b1;
          end
        end
      endcase
    end else if (armed && periodic) begin
      // Gate low freezes the count and forces OUT high
      out_q <= 1'b1;
    end
  end

  // Idle channel shows the initial level of its mode
  assign out      = armed ? out_q : periodic;
  assign ch.count = count_q;

  a_square_even: assert property (@(posedge CLK) disable iff (rst)
    (armed && mode == pit_pkg::MODE_SQUARE) |-> !count_q[0])
    else $error("pit_counter: odd count in square wave mode");

endmodule

`default_nettype wire

// File: hw/pit_decode.sv
`default_nettype none
`timescale 1ns/10ps

module pit_decode (
  input  wire                       CLK,
  input  wire                       rst,
  input  wire [1:0]                 addr,
  input  wire                       wr,
  input  wire                       rd,
  input  wire [pit_pkg::BYTE_W-1:0] wdata,
  pit_chan_if.decoder               ch0,
  pit_chan_if.decoder               ch1,
  pit_chan_if.decoder               ch2
);

  logic [1:0] sc;
  logic       is_latch;
  logic [2:0] cw_sel;
  logic [2:0] latch_sel;
  logic [2:0] cnt_sel;
  logic [2:0] rd_sel;

  // SC in bits 7:6, RW in bits 5:4
  assign sc       = wdata[7:6];
  assign is_latch = (wdata[5:4] == pit_pkg::ACC_LATCH);

  always_comb begin
    cw_sel    = '0;
    latch_sel = '0;
    cnt_sel   = '0;
    rd_sel    = '0;
    // SC of 3 is read-back on the real part, ignored here
    if (wr && addr == pit_pkg::CTRL_ADDR && sc != 2'd3) begin
      if (is_latch) begin
        latch_sel[sc] = 1'b1;
      end else begin
        cw_sel[sc] = 1'b1;
      end
    end
    if (wr && addr != pit_pkg::CTRL_ADDR) begin
      cnt_sel[addr] = 1'b1;
    end
    if (rd && addr != pit_pkg::CTRL_ADDR) begin
      rd_sel[addr] = 1'b1;
    end
  end

  assign ch0.cw_wr     = cw_sel[0];
  assign ch0.latch_cmd = latch_sel[0];
  assign ch0.cnt_wr    = cnt_sel[0];
  assign ch0.rd_sel    = rd_sel[0];
  assign ch0.rd_any    = rd;

  assign ch1.cw_wr     = cw_sel[1];
  assign ch1.latch_cmd = latch_sel[1];
  assign ch1.cnt_wr    = cnt_sel[1];
  assign ch1.rd_sel    = rd_sel[1];
  assign ch1.rd_any    = rd;

  assign ch2.cw_wr     = cw_sel[2];
  assign ch2.latch_cmd = latch_sel[2];
  assign ch2.cnt_wr    = cnt_sel[2];
  assign ch2.rd_sel    = rd_sel[2];
  assign ch2.rd_any    = rd;

  // One bus access per cycle reaches one channel at most
  a_one_strobe: assert property (@(posedge CLK) disable iff (rst)
    $onehot0({cw_sel, latch_sel, cnt_sel, rd_sel}))
    else $error("pit_decode: more than one channel strobe in a cycle");

endmodule

`default_nettype wire

// File: hw/pit_pkg.sv
`default_nettype none

package pit_pkg;

  // Counter and bus widths are fixed by the device
  localparam int COUNT_W = 16;
  localparam int BYTE_W  = 8;

  // Address 3 carries control words and latch commands
  localparam logic [1:0] CTRL_ADDR = 2'd3;

  // Modes 1, 4 and 5 decode to MODE_TC_INT
  typedef enum logic [2:0] {
    MODE_TC_INT   = 3'd0,
    MODE_RATE_GEN = 3'd2,
    MODE_SQUARE   = 3'd3
  } pit_mode_e;

  // RW field of the control word, bits 5:4
  typedef enum logic [1:0] {
    ACC_LATCH = 2'd0,
    ACC_LSB   = 2'd1,
    ACC_MSB   = 2'd2,
    ACC_BOTH  = 2'd3
  } pit_access_e;

endpackage

`default_nettype wire

// File: hw/pit_readback.sv
`default_nettype none
`timescale 1ns/10ps

module pit_readback (
  input  wire                         CLK,
  input  wire                         rst,
  output logic [pit_pkg::BYTE_W-1:0]  rdata,
  pit_chan_if.readback                ch
);

  localparam int CW = pit_pkg::COUNT_W;
  localparam int BW = pit_pkg::BYTE_W;

  pit_pkg::pit_access_e access;
  logic [CW-1:0]        latch_q;
  logic [CW-1:0]        src;
  logic                 held;
  logic                 rd_msb;
  logic [BW-1:0]        rdata_q;

  assign access = pit_pkg::pit_access_e'(ch.access);

  // Frozen value wins until it has been read out
  assign src = held ? latch_q : ch.count;

  // A second latch command while held is ignored
  always_ff @(posedge CLK) begin
    if (ch.latch_cmd && !held) begin
      latch_q <= ch.count;
    end
  end

  always_ff @(posedge CLK) begin
    if (rst) begin
      held   <= 1'b0;
      rd_msb <= 1'b0;
    end else if (ch.cw_wr) begin
      held   <= 1'b0;
      rd_msb <= 1'b0;
    end else if (ch.latch_cmd) begin
      held <= 1'b1;
    end else if (ch.rd_sel) begin
      if (access == pit_pkg::ACC_BOTH) begin
        rd_msb <= ~rd_msb;
        if (rd_msb) begin
          held <= 1'b0;
        end
      end else begin
        held <= 1'b0;
      end
    end
  end

  // Read byte register, zero once another channel is read
  always_ff @(posedge CLK) begin
    if (rst) begin
      rdata_q <= '0;
    end else if (ch.rd_sel) begin
      case (access)
        pit_pkg::ACC_MSB:  rdata_q <= src[CW-1:BW];
        pit_pkg::ACC_BOTH: rdata_q <= rd_msb ? src[CW-1:BW] : src[BW-1:0];
        default:           rdata_q <= src[BW-1:0];
      endcase
    end else if (ch.rd_any) begin
      rdata_q <= '0;
    end
  end

  assign rdata = rdata_q;

  a_latch_vs_read: assert property (@(posedge CLK) disable iff (rst)
    !(ch.latch_cmd && ch.rd_sel))
    else $error("pit_readback: latch command and read in the same cycle");

endmodule

`default_nettype wire

// File: hw/pit_top.sv
`default_nettype none
`timescale 1ns/10ps

module pit_top (
  input  wire        CLK,
  input  wire        rst,
  input  wire [1:0]  addr,
  input  wire        wr,
  input  wire        rd,
  input  wire [7:0]  wdata,
  input  wire        gate0,
  input  wire        gate1,
  input  wire        gate2,
  output logic [7:0] rdata,
  output logic       out0,
  output logic       out1,
  output logic       out2
);

  logic [2:0] gate_v;
  logic [2:0] out_v;
  logic [7:0] rd_byte [3];

  pit_chan_if ch_if [3] ();

  assign gate_v = {gate2, gate1, gate0};

  pit_decode pit_decode_inst (
    .CLK   (CLK),
    .rst   (rst),
    .addr  (addr),
    .wr    (wr),
    .rd    (rd),
    .wdata (wdata),
    .ch0   (ch_if[0]),
    .ch1   (ch_if[1]),
    .ch2   (ch_if[2])
  );

  for (genvar i = 0; i < 3; i++) begin : g_chan
    pit_chan_regs pit_chan_regs_inst (
      .CLK   (CLK),
      .rst   (rst),
      .wdata (wdata),
      .ch    (ch_if[i])
    );

    pit_counter pit_counter_inst (
      .CLK  (CLK),
      .rst  (rst),
      .gate (gate_v[i]),
      .out  (out_v[i]),
      .ch   (ch_if[i])
    );

    pit_readback pit_readback_inst (
      .CLK   (CLK),
      .rst   (rst),
      .rdata (rd_byte[i]),
      .ch    (ch_if[i])
    );
  end

  // Only the last channel read holds a nonzero byte
  assign rdata = rd_byte[0] | rd_byte[1] | rd_byte[2];

  assign out0 = out_v[0];
  assign out1 = out_v[1];
  assign out2 = out_v[2];

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build the PIT testbench with Verilator, run it, and check the log
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_pit -f compile.f -o tb_pit \
  && ./obj_dir/tb_pit > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "sim failed" sim.log && exit 1
grep -q "sim passed" sim.log || exit 1
exit 0

// File: include/pit_tb_model.svh
`ifndef PIT_TB_MODEL_SVH
`define PIT_TB_MODEL_SVH

// Reference state of the three channels, stepped at every rising edge
logic [1:0]  m_mode   [3];
logic [1:0]  m_acc    [3];
logic [15:0] m_cnt    [3];
logic        m_wr_msb [3];
logic        m_load   [3];
logic [15:0] m_count  [3];
logic        m_armed  [3];
logic        m_outq   [3];
logic [15:0] m_latch  [3];
logic        m_held   [3];
logic        m_rd_msb [3];
logic [7:0]  m_rbyte  [3];

// Idle channel shows the initial level of its mode
function automatic logic model_out(input int c);
  return m_armed[c] ? m_outq[c] : (m_mode[c] != 2'd0);
endfunction

task automatic model_reset();
  for (int c = 0; c < 3; c++) begin
    m_mode[c]   = 2'd0;
    m_acc[c]    = 2'd1;
    m_cnt[c]    = '0;
    m_wr_msb[c] = 1'b0;
    m_load[c]   = 1'b0;
    m_count[c]  = '0;
    m_armed[c]  = 1'b0;
    m_outq[c]   = 1'b0;
    m_latch[c]  = '0;
    m_held[c]   = 1'b0;
    m_rd_msb[c] = 1'b0;
    m_rbyte[c]  = '0;
  end
endtask

// One clock edge with the bus and gate levels seen at that edge
task automatic model_step(input logic [1:0] a, input logic w, input logic r,
                          input logic [7:0] d, input logic [2:0] g);
  logic [15:0] reload;
  logic [15:0] src;
  logic        cw;
  logic        lat;
  logic        cwr;
  logic        rds;
  for (int c = 0; c < 3; c++) begin
    cw     = w && a == 2'd3 && d[7:6] == c && d[5:4] != 2'd0;
    lat    = w && a == 2'd3 && d[7:6] == c && d[5:4] == 2'd0;
    cwr    = w && a == c;
    rds    = r && a == c;
    reload = (m_mode[c] == 2'd3) ? {m_cnt[c][15:1], 1'b0} : m_cnt[c];
    src    = m_held[c] ? m_latch[c] : m_count[c];
    // Readback side sees the count from before this edge
    if (lat && !m_held[c]) m_latch[c] = m_count[c];
    if (rds) begin
      case (m_acc[c])
        2'd2:    m_rbyte[c] = src[15:8];
        2'd3:    m_rbyte[c] = m_rd_msb[c] ? src[15:8] : src[7:0];
        default: m_rbyte[c] = src[7:0];
      endcase
    end else if (r) begin
      m_rbyte[c] = '0;
    end
    if (cw) begin
      m_held[c]   = 1'b0;
      m_rd_msb[c] = 1'b0;
    end else if (lat) begin
      m_held[c] = 1'b1;
    end else if (rds) begin
      if (m_acc[c] != 2'd3 || m_rd_msb[c]) m_held[c] = 1'b0;
      if (m_acc[c] == 2'd3) m_rd_msb[c] = ~m_rd_msb[c];
    end
    // Counter
    if (cw) begin
      m_armed[c] = 1'b0;
    end else if (m_load[c]) begin
      m_count[c] = reload;
      m_armed[c] = 1'b1;
      m_outq[c]  = (m_mode[c] != 2'd0);
    end else if (m_armed[c] && g[c]) begin
      if (m_mode[c] == 2'd2) begin
        m_outq[c]  = (m_count[c] != 16'd1);
        m_count[c] = (m_count[c] == 16'd1) ? reload : m_count[c] - 16'd1;
      end else if (m_mode[c] == 2'd3) begin
        if (m_count[c] == 16'd2) m_outq[c] = ~m_outq[c];
        m_count[c] = (m_count[c] == 16'd2) ? reload : m_count[c] - 16'd2;
      end else begin
        if (m_count[c] == 16'd1) m_outq[c] = 1'b1;
        m_count[c] = m_count[c] - 16'd1;
      end
    end else if (m_armed[c] && m_mode[c] != 2'd0) begin
      m_outq[c] = 1'b1;
    end
    // Mode, access and count registers
    if (cw) begin
      m_mode[c]   = (d[2:1] == 2'd2 || d[2:1] == 2'd3) ? d[2:1] : 2'd0;
      m_acc[c]    = d[5:4];
      m_wr_msb[c] = 1'b0;
      m_load[c]   = 1'b0;
    end else if (cwr) begin
      case (m_acc[c])
        2'd1:    m_cnt[c] = {8'h00, d};
        2'd2:    m_cnt[c] = {d, 8'h00};
        default: begin
          if (m_wr_msb[c]) m_cnt[c][15:8] = d;
          else m_cnt[c][7:0] = d;
        end
      endcase
      m_load[c] = (m_acc[c] == 2'd3) ? m_wr_msb[c] : 1'b1;
      if (m_acc[c] == 2'd3) m_wr_msb[c] = ~m_wr_msb[c];
    end else begin
      m_load[c] = 1'b0;
    end
  end
endtask

`endif

// File: test/tb_pit.sv
`default_nettype none
`timescale 1ns/10ps

module tb_pit;

  // Cycle budget of each test summed for the watchdog
  localparam int TEST_CYCLES = 20 + 100 + 250 + 300 + 100 + 100 + 3100;
  localparam logic [1:0] CTRL = pit_pkg::CTRL_ADDR;

  logic        CLK;
  logic        rst;
  logic [1:0]  addr;
  logic        wr;
  logic        rd;
  logic [7:0]  wdata;
  logic [2:0]  gate;
  logic [7:0]  rdata;
  logic        out0;
  logic        out1;
  logic        out2;
  string       test_name;
  int unsigned seed_val;
  logic [1:0]  ch;
  logic [15:0] n;
  logic [15:0] lat;
  int          k;

  `include "pit_tb_model.svh"

  pit_top pit_top_inst (
    .CLK   (CLK),
    .rst   (rst),
    .addr  (addr),
    .wr    (wr),
    .rd    (rd),
    .wdata (wdata),
    .gate0 (gate[0]),
    .gate1 (gate[1]),
    .gate2 (gate[2]),
    .rdata (rdata),
    .out0  (out0),
    .out1  (out1),
    .out2  (out2)
  );

  initial CLK = 1'b0;
  always #10 CLK = ~CLK;

  task automatic check_val(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
    if (expected !== actual) begin
      $display("error %s expected %0h actual %0h", name, expected, actual);
      $display("sim failed");
      $fatal(1, "value mismatch in %s", name);
    end
  endtask

  function automatic logic [7:0] ctrl_word(input logic [1:0] c, input logic [1:0] acc,
                                           input logic [2:0] mode);
    return {c, acc, mode, 1'b0};
  endfunction

  function automatic logic dut_out(input logic [1:0] c);
    logic [2:0] o;
    o = {out2, out1, out0};
    return o[c];
  endfunction

  // One bus cycle driven on the falling edge
  task automatic bus_cycle(input logic w, input logic r, input logic [1:0] a,
                           input logic [7:0] d);
    @(negedge CLK);
    wr    = w;
    rd    = r;
    addr  = a;
    wdata = d;
  endtask

  task automatic idle(input int cycles);
    repeat (cycles) bus_cycle(1'b0, 1'b0, 2'd0, 8'h00);
  endtask

  task automatic bus_write(input logic [1:0] a, input logic [7:0] d);
    bus_cycle(1'b1, 1'b0, a, d);
    idle(1);
  endtask

  task automatic bus_read(input logic [1:0] a);
    bus_cycle(1'b0, 1'b1, a, 8'h00);
    idle(1);
  endtask

  // Cycles until the channel output reaches the given level
  task automatic wait_out(input logic [1:0] c, input logic level, output int cycles);
    cycles = 0;
    do begin
      idle(1);
      cycles++;
    end while (dut_out(c) !== level && cycles < 200);
  endtask

  always @(posedge CLK) begin
    if (rst) begin
      model_reset();
    end else begin
      model_step(addr, wr, rd, wdata, gate);
    end
  end

  // Every DUT output against the model at each falling edge
  always @(negedge CLK) begin
    if (!rst) begin
      check_val({test_name, " out0"}, 32'(model_out(0)), 32'(out0));
      check_val({test_name, " out1"}, 32'(model_out(1)), 32'(out1));
      check_val({test_name, " out2"}, 32'(model_out(2)), 32'(out2));
      check_val({test_name, " rdata"}, 32'(m_rbyte[0] | m_rbyte[1] | m_rbyte[2]),
                32'(rdata));
    end
  end

  initial begin
    #(TEST_CYCLES * 20 * 3 / 2);
    $display("watchdog expired before the tests finished");
    $display("sim failed");
    $fatal(1, "timeout");
  end

  initial begin
    rst       = 1'b1;
    addr      = 2'd0;
    wr        = 1'b0;
    rd        = 1'b0;
    wdata     = 8'h00;
    gate      = 3'b111;
    test_name = "reset";
    seed_val  = $urandom(32'hc8fe41d3);
    model_reset();
    repeat (2) @(negedge CLK);
    rst = 1'b0;

    // Mode 0 OUT rises N+1 cycles after the last count byte
    test_name = "mode0";
    ch = 2'($urandom % 3);
    n  = 16'(2 + $urandom % 39);
    bus_write(CTRL, ctrl_word(ch, pit_pkg::ACC_BOTH, pit_pkg::MODE_TC_INT));
    bus_write(ch, n[7:0]);
    bus_write(ch, n[15:8]);
    wait_out(ch, 1'b1, k);
    check_val("mode0 rise cycle", 32'(n) + 1, 32'(k));
    idle(20);

    test_name = "mode2";
    ch = 2'($urandom % 3);
    n  = 16'(2 + $urandom % 39);
    bus_write(CTRL, ctrl_word(ch, pit_pkg::ACC_BOTH, pit_pkg::MODE_RATE_GEN));
    bus_write(ch, n[7:0]);
    bus_write(ch, n[15:8]);
    wait_out(ch, 1'b0, k);
    repeat (4) begin
      wait_out(ch, 1'b1, k);
      check_val("mode2 low width", 32'd1, 32'(k));
      wait_out(ch, 1'b0, k);
      check_val("mode2 period", 32'(n), 32'(k) + 1);
    end

    test_name = "mode3";
    ch = 2'($urandom % 3);
    n  = 16'(4 + 2 * ($urandom % 19));
    bus_write(CTRL, ctrl_word(ch, pit_pkg::ACC_BOTH, pit_pkg::MODE_SQUARE));
    bus_write(ch, n[7:0]);
    bus_write(ch, n[15:8]);
    wait_out(ch, 1'b0, k);
    repeat (3) begin
      wait_out(ch, 1'b1, k);
      check_val("mode3 high half", 32'(n / 2), 32'(k));
      wait_out(ch, 1'b0, k);
      check_val("mode3 low half", 32'(n / 2), 32'(k));
    end
    gate[ch] = 1'b0;
    idle(2 * 32'(n));
    check_val("mode3 gate low out", 32'd1, 32'(dut_out(ch)));
    gate[ch] = 1'b1;
    idle(2 * 32'(n));

    test_name = "access";
    for (int i = 0; i < 3; i++) begin
      ch = 2'(i);
      bus_write(CTRL, ctrl_word(ch, pit_pkg::ACC_LSB, pit_pkg::MODE_TC_INT));
      bus_write(ch, 8'($urandom));
      idle(3);
      bus_read(ch);
      bus_write(CTRL, ctrl_word(ch, pit_pkg::ACC_MSB, pit_pkg::MODE_RATE_GEN));
      bus_write(ch, 8'(1 + $urandom % 255));
      idle(3);
      bus_read(ch);
      bus_read(ch);
    end

    // Latched bytes must not follow the running count
    test_name = "latch";
    ch = 2'($urandom % 3);
    n  = 16'(16'h1000 + $urandom % 16'h8000);
    bus_write(CTRL, ctrl_word(ch, pit_pkg::ACC_BOTH, pit_pkg::MODE_TC_INT));
    bus_write(ch, n[7:0]);
    bus_write(ch, n[15:8]);
    idle(5);
    bus_write(CTRL, {ch, 6'b000000});
    lat = m_latch[ch];
    idle(3);
    bus_read(ch);
    check_val("latch lsb", 32'(lat[7:0]), 32'(rdata));
    idle(4);
    bus_read(ch);
    check_val("latch msb", 32'(lat[15:8]), 32'(rdata));
    bus_read(ch);
    bus_read(ch);

    test_name = "random";
    for (int i = 0; i < 3000; i++) begin
      ch = 2'($urandom % 3);
      if (wr || rd) begin
        // Bus strobes never stay high for two cycles
        bus_cycle(1'b0, 1'b0, 2'd0, 8'h00);
      end else begin
        case ($urandom % 16)
          0:       bus_cycle(1'b1, 1'b0, CTRL, 8'($urandom));
          1, 2, 3: bus_cycle(1'b1, 1'b0, ch, 8'($urandom));
          4, 5, 6: bus_cycle(1'b0, 1'b1, 2'($urandom), 8'h00);
          7: begin
            bus_cycle(1'b0, 1'b0, 2'd0, 8'h00);
            gate[ch] = ~gate[ch];
          end
          default: bus_cycle(1'b0, 1'b0, 2'd0, 8'h00);
        endcase
      end
    end
    idle(5);

    $display("sim passed");
    $finish;
  end

endmodule

`default_nettype wire
